/* compile.f */
design/spi_reg_pkg.sv
design/spi_pin_sync.sv
design/spi_slave.sv
design/spi_reg_bank.sv
design/spi_reg_top.sv
tb/spi_reg_assertions.sv
tb/spi_reg_tb.sv

/* design/spi_pin_sync.sv */
// SPI pin oversampling in the reg_clk domain
//   Two-stage synchronizers for cs, ck and mosi
//   Registered SCK rise/fall and chip-select fall pulses
`timescale 1ns/1ns
`default_nettype none

module spi_pin_sync (
  input  logic                   reg_clk,
  input  logic                   i_spi_rst,
  input  logic                   i_spi_cs,
  input  logic                   i_spi_ck,
  input  logic                   i_spi_mosi,
  output spi_reg_pkg::spi_pins_t o_pins
);
  import spi_reg_pkg::*;

  logic [2:0] sr_cs;                       // [0] first flop, [2] edge history
  logic [2:0] sr_ck;
  logic [1:0] sr_mosi;
  logic       ck_rise;
  logic       ck_fall;
  logic       cs_fall;

  // ------------------------------------------------------------
  // Synchronizer chains
  // ------------------------------------------------------------
  always_ff @(posedge reg_clk) begin
    if (i_spi_rst) begin
      sr_cs   <= '1;                       // Idle level, no false cs_fall
      sr_ck   <= '1;                       // Mode 3 clock idles high
      sr_mosi <= '0;
    end else begin
      sr_cs   <= {sr_cs[1:0], i_spi_cs};
      sr_ck   <= {sr_ck[1:0], i_spi_ck};
      sr_mosi <= {sr_mosi[0], i_spi_mosi};
    end
  end

  // Edge pulses, one flop after the compare
  always_ff @(posedge reg_clk) begin
    if (i_spi_rst) begin
      ck_rise <= 1'b0;
      ck_fall <= 1'b0;
      cs_fall <= 1'b0;
    end else begin
      ck_rise <= ~sr_ck[2] &  sr_ck[1];
      ck_fall <=  sr_ck[2] & ~sr_ck[1];
      cs_fall <=  sr_cs[2] & ~sr_cs[1];
    end
  end

  // Levels lag the pins by two cycles, pulses by three
  assign o_pins.cs      = sr_cs[1];
  assign o_pins.mosi    = sr_mosi[1];
  assign o_pins.ck_rise = ck_rise;
  assign o_pins.ck_fall = ck_fall;
  assign o_pins.cs_fall = cs_fall;

endmodule

`default_nettype wire

/* design/spi_reg_bank.sv */
// Byte register bank behind the SPI slave
//   Write decode from the write command, low data byte stored
//   Flat read vector, register k at bits [8k+7:8k]
`timescale 1ns/1ns
`default_nettype none

module spi_reg_bank #(
  parameter logic [7:0] G_ADR_BASE = 8'h00,
  parameter int         G_REG_NUM  = 8
) (
  input  logic                     reg_clk,
  input  logic                     i_spi_rst,
  input  spi_reg_pkg::reg_wr_t     i_reg_wr,
  output logic [G_REG_NUM*8-1:0]   o_reg_rd_data
);
  import spi_reg_pkg::*;

  logic [7:0]           regs [G_REG_NUM];
  logic [SPI_ADR_W-1:0] wr_idx;            // Offset from base
  logic                 wr_hit;            // Strobe lands on a register
  logic [G_REG_NUM-1:0] wr_sel;            // One-hot write enable

  // ------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------
  assign wr_idx = i_reg_wr.addr - G_ADR_BASE;

  // Below base would wrap into range, so check both ends
  assign wr_hit = i_reg_wr.en &&
                  (i_reg_wr.addr >= G_ADR_BASE) &&
                  (wr_idx < G_REG_NUM);

  always_comb begin
    wr_sel = '0;
    for (int i = 0; i < G_REG_NUM; i++) begin
      if (wr_hit && (wr_idx == i)) begin
        wr_sel[i] = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Registers and read vector
  // ------------------------------------------------------------
  for (genvar gi = 0; gi < G_REG_NUM; gi++) begin : g_reg
    always_ff @(posedge reg_clk) begin
      if (i_spi_rst) begin
        regs[gi] <= '0;
      end else if (wr_sel[gi]) begin
        regs[gi] <= i_reg_wr.data[7:0];    // Bits 23..8 go to the strobe only
      end
    end

    assign o_reg_rd_data[gi*8 +: 8] = regs[gi];  // Combinational read
  end

endmodule

`default_nettype wire

/* design/spi_reg_pkg.sv */
// Shared types for the SPI register-access slave
//   SPI_FRAME_W and field widths of the SPI frame
//   spi_frame_u  32-bit frame word, write view and read view
//   spi_pins_t   synchronized SPI pin levels and edge pulses
//   reg_wr_t     write command toward the user side
`default_nettype none

package spi_reg_pkg;

  localparam int SPI_FRAME_W = 32;         // Bits per chip-select frame
  localparam int SPI_ADR_W   = 8;          // Register address byte
  localparam int SPI_DATA_W  = SPI_FRAME_W - SPI_ADR_W;

  // ------------------------------------------------------------
  // Frame word, MSB first on the wire
  // ------------------------------------------------------------
  typedef struct packed {
    logic [SPI_ADR_W-1:0]  addr;           // Target register
    logic [SPI_DATA_W-1:0] data;           // Write payload
  } spi_frame_wr_t;

  typedef struct packed {
    logic [SPI_ADR_W-1:0] addr;            // Responder address
    logic [7:0]           sel;             // Byte index of the pair
    logic [15:0]          dc;              // MISO half, MOSI ignored
  } spi_frame_rd_t;

  typedef union packed {
    spi_frame_wr_t wr;
    spi_frame_rd_t rd;
  } spi_frame_u;

  // ------------------------------------------------------------
  // Pin events in the reg_clk domain
  // ------------------------------------------------------------
  typedef struct packed {
    logic cs;                              // Chip-select level
    logic mosi;                            // MOSI level
    logic ck_rise;                         // One-cycle pulse
    logic ck_fall;                         // One-cycle pulse
    logic cs_fall;                         // Frame start pulse
  } spi_pins_t;

  // Write strobe plus payload, valid together
  typedef struct packed {
    logic [SPI_ADR_W-1:0]  addr;
    logic [SPI_DATA_W-1:0] data;
    logic                  en;
  } reg_wr_t;

endpackage

`default_nettype wire

/* design/spi_reg_top.sv */
// SPI register-access subsystem top level
//   Pin synchronizer, frame slave and byte register bank
//   Write command also exported to the user side
`timescale 1ns/1ns
`default_nettype none

module spi_reg_top #(
  parameter logic [7:0] G_ADR_BASE       = 8'h00,
  parameter logic [7:0] G_ADR_SPACE_SIZE = 8'hFF,
  parameter logic [7:0] G_ADR_RESPONDER  = 8'hFE,
  parameter int         G_REG_NUM        = 8
) (
  input  logic                 reg_clk,
  input  logic                 i_spi_rst,
  input  logic                 i_spi_cs,
  input  logic                 i_spi_ck,
  input  logic                 i_spi_mosi,
  output logic                 o_spi_miso,
  output spi_reg_pkg::reg_wr_t o_reg_wr
);
  import spi_reg_pkg::*;

  spi_pins_t              pins;            // Synchronized pin events
  logic [G_REG_NUM*8-1:0] reg_rd_data;     // Bank contents, flat

  // ------------------------------------------------------------
  // Pin oversampling
  // ------------------------------------------------------------
  spi_pin_sync u_pin_sync (
    .reg_clk    (reg_clk),
    .i_spi_rst  (i_spi_rst),
    .i_spi_cs   (i_spi_cs),
    .i_spi_ck   (i_spi_ck),
    .i_spi_mosi (i_spi_mosi),
    .o_pins     (pins)
  );

  // Frame handling
  spi_slave #(
    .G_ADR_BASE       (G_ADR_BASE),
    .G_ADR_SPACE_SIZE (G_ADR_SPACE_SIZE),
    .G_ADR_RESPONDER  (G_ADR_RESPONDER),
    .G_REG_NUM        (G_REG_NUM)
  ) u_slave (
    .reg_clk       (reg_clk),
    .i_spi_rst     (i_spi_rst),
    .i_pins        (pins),
    .i_reg_rd_data (reg_rd_data),
    .o_reg_wr      (o_reg_wr),             // Also feeds the bank
    .o_spi_miso    (o_spi_miso)
  );

  // Register storage
  spi_reg_bank #(
    .G_ADR_BASE (G_ADR_BASE),
    .G_REG_NUM  (G_REG_NUM)
  ) u_reg_bank (
    .reg_clk       (reg_clk),
    .i_spi_rst     (i_spi_rst),
    .i_reg_wr      (o_reg_wr),
    .o_reg_rd_data (reg_rd_data)
  );

endmodule

`default_nettype wire

/* design/spi_slave.sv */
// SPI mode 3 register-access slave
//   Frame FSM with bit counter and address-space decode
//   Write strobe after a full 32-bit write frame
//   16-bit MISO shifter for responder read frames
`timescale 1ns/1ns
`default_nettype none

module spi_slave #(
  parameter logic [7:0] G_ADR_BASE       = 8'h00,
  parameter logic [7:0] G_ADR_SPACE_SIZE = 8'hFF,
  parameter logic [7:0] G_ADR_RESPONDER  = 8'hFE,
  parameter int         G_REG_NUM        = 8
) (
  input  logic                         reg_clk,
  input  logic                         i_spi_rst,
  input  spi_reg_pkg::spi_pins_t       i_pins,
  input  logic [G_REG_NUM*8-1:0]       i_reg_rd_data,
  output spi_reg_pkg::reg_wr_t         o_reg_wr,
  output logic                         o_spi_miso
);
  import spi_reg_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,                               // Waiting for cs_fall
    ST_RCV_ADR,                            // First byte
    ST_M2S,                                // Write payload
    ST_M2S_END,                            // Issue strobe
    ST_S2M_SEL,                            // Byte-select of read frame
    ST_S2M,                                // Read data out on MISO
    ST_WAIT_END                            // Not ours, wait for cs high
  } fsm_state_t;

  fsm_state_t     fsm_state;
  logic [4:0]     bit_cnt;                 // Rising edges seen, 0..31
  logic [4:0]     bit_idx;                 // Frame position of next bit
  spi_frame_u     frame;
  spi_frame_u     frame_nxt;               // Frame with current MOSI bit
  logic [SPI_FRAME_W-1:0] frame_bits;
  logic [7:0]     rd_sel;
  logic [15:0]    rd_pair;
  logic [15:0]    sr_miso;
  logic           adr_in_space;
  logic           adr_is_resp;

  // ------------------------------------------------------------
  // Byte lookup in the read vector, zero past the last register
  // ------------------------------------------------------------
  function automatic logic [7:0] rd_byte(input logic [8:0]             idx,
                                         input logic [G_REG_NUM*8-1:0] data);
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < G_REG_NUM; i++) begin
      if (idx == i) begin
        b = data[i*8 +: 8];
      end
    end
    return b;
  endfunction

  // Bits land at their final place, MSB first, so the views hold mid-frame
  assign bit_idx = 5'(SPI_FRAME_W - 1) - bit_cnt;

  always_comb begin
    frame_bits          = frame;
    frame_bits[bit_idx] = i_pins.mosi;
    frame_nxt           = frame_bits;
  end

  // Address checks on the byte being completed, 9 bits against wrap
  assign adr_in_space = ({1'b0, frame_nxt.wr.addr} >= {1'b0, G_ADR_BASE}) &&
                        ({1'b0, frame_nxt.wr.addr} <=
                         ({1'b0, G_ADR_BASE} + {1'b0, G_ADR_SPACE_SIZE}));
  assign adr_is_resp  = (frame_nxt.wr.addr == G_ADR_RESPONDER);

  // Upper byte sel+1, lower byte sel
  assign rd_pair = {rd_byte({1'b0, rd_sel} + 9'd1, i_reg_rd_data),
                    rd_byte({1'b0, rd_sel}, i_reg_rd_data)};

  // ------------------------------------------------------------
  // Frame FSM
  // ------------------------------------------------------------
  always_ff @(posedge reg_clk) begin
    if (i_spi_rst) begin
      fsm_state   <= ST_IDLE;
      bit_cnt     <= '0;
      frame       <= '0;
      rd_sel      <= '0;
      sr_miso     <= '0;
      o_reg_wr.en <= 1'b0;
    end else begin
      o_reg_wr.en <= 1'b0;                 // Strobe is one cycle only

      if (i_pins.cs_fall) begin            // New frame, drop anything pending
        fsm_state <= ST_RCV_ADR;
        bit_cnt   <= '0;
        frame     <= '0;
        rd_sel    <= '0;
        sr_miso   <= '0;
      end else begin
        case (fsm_state)
          ST_IDLE: begin
            // Only cs_fall leaves idle
          end

          ST_RCV_ADR: begin
            if (i_pins.cs) begin
              fsm_state <= ST_IDLE;        // Aborted in the address byte
            end else if (i_pins.ck_rise) begin
              frame   <= frame_nxt;
              bit_cnt <= bit_cnt + 5'd1;
              if (bit_cnt == 5'd7) begin
                if (!adr_in_space) begin
                  fsm_state <= ST_WAIT_END;
                end else if (adr_is_resp) begin
                  fsm_state <= ST_S2M_SEL;
                end else begin
                  fsm_state <= ST_M2S;
                end
              end
            end
          end

          ST_M2S: begin
            if (i_pins.cs) begin
              fsm_state <= ST_IDLE;        // Short frame, no strobe
            end else if (i_pins.ck_rise) begin
              frame <= frame_nxt;
              if (bit_cnt == 5'(SPI_FRAME_W - 1)) begin
                fsm_state <= ST_M2S_END;
              end else begin
                bit_cnt <= bit_cnt + 5'd1;
              end
            end
          end

          ST_M2S_END: begin
            if (!i_pins.cs) begin          // cs gone high means write dropped
              o_reg_wr.addr <= frame.wr.addr;
              o_reg_wr.data <= frame.wr.data;
              o_reg_wr.en   <= 1'b1;
            end
            fsm_state <= ST_IDLE;
          end

          ST_S2M_SEL: begin
            if (i_pins.cs) begin
              fsm_state <= ST_IDLE;
            end else if (i_pins.ck_rise) begin
              frame   <= frame_nxt;
              bit_cnt <= bit_cnt + 5'd1;
              if (bit_cnt == 5'd15) begin
                rd_sel    <= frame_nxt.rd.sel;
                fsm_state <= ST_S2M;
              end
            end
          end

          ST_S2M: begin
            if (i_pins.cs) begin
              fsm_state <= ST_IDLE;
            end else begin
              if (i_pins.ck_rise) begin
                if (bit_cnt == 5'(SPI_FRAME_W - 1)) begin
                  fsm_state <= ST_WAIT_END;  // Last bit sampled by master
                end else begin
                  bit_cnt <= bit_cnt + 5'd1;
                end
              end
              if (i_pins.ck_fall) begin
                if (bit_cnt == 5'd16) begin
                  sr_miso <= rd_pair;      // Load on first fall of second half
                end else begin
                  sr_miso <= {sr_miso[14:0], 1'b0};
                end
              end
            end
          end

          ST_WAIT_END: begin
            if (i_pins.cs) begin
              fsm_state <= ST_IDLE;
            end
          end

          default: fsm_state <= ST_IDLE;
        endcase
      end
    end
  end

  assign o_spi_miso = sr_miso[15];         // MSB first

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the SPI register testbench with Verilator, run it, then check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module spi_reg_tb -o spi_reg_sim > build.log 2>&1 \
  && ./obj_dir/spi_reg_sim +verilator+error+limit+1000 > sim.log 2>&1

grep -qx "TB PASSED" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  && exit 0 \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* tb/spi_reg_assertions.sv */
// Concurrent checks on the spi_slave write strobe
//   One-cycle strobe, strobe address inside the space, no strobe with cs high
//   Bound into every spi_slave instance
`timescale 1ns/1ns
`default_nettype none

module spi_reg_assertions #(
  parameter logic [7:0] G_ADR_BASE       = 8'h00,
  parameter logic [7:0] G_ADR_SPACE_SIZE = 8'hFF,
  parameter logic [7:0] G_ADR_RESPONDER  = 8'hFE
) (
  input logic                   reg_clk,
  input logic                   i_spi_rst,
  input spi_reg_pkg::spi_pins_t i_pins,
  input spi_reg_pkg::reg_wr_t   o_reg_wr
);
  import spi_reg_pkg::*;

  localparam logic [8:0] ADR_LO = {1'b0, G_ADR_BASE};
  localparam logic [8:0] ADR_HI = {1'b0, G_ADR_BASE} + {1'b0, G_ADR_SPACE_SIZE};

  int n_fail = 0;                          // Read by the testbench summary

  a_strobe_single: assert property (@(posedge reg_clk) disable iff (i_spi_rst)
    o_reg_wr.en |=> !o_reg_wr.en)
    else begin
      n_fail++;
      $error("write strobe held for two cycles");
    end

  // Strobe only for in-space, non-responder addresses
  a_strobe_addr: assert property (@(posedge reg_clk) disable iff (i_spi_rst)
    o_reg_wr.en |-> ({1'b0, o_reg_wr.addr} >= ADR_LO) &&
                    ({1'b0, o_reg_wr.addr} <= ADR_HI) &&
                    (o_reg_wr.addr != G_ADR_RESPONDER))
    else begin
      n_fail++;
      $error("write strobe with address %h outside the space", o_reg_wr.addr);
    end

  a_strobe_cs_low: assert property (@(posedge reg_clk) disable iff (i_spi_rst)
    o_reg_wr.en |-> !i_pins.cs)            // cs level already two cycles late
    else begin
      n_fail++;
      $error("write strobe while chip-select is high");
    end

endmodule

bind spi_slave spi_reg_assertions #(
  .G_ADR_BASE       (G_ADR_BASE),
  .G_ADR_SPACE_SIZE (G_ADR_SPACE_SIZE),
  .G_ADR_RESPONDER  (G_ADR_RESPONDER)
) u_slave_assert (
  .reg_clk   (reg_clk),
  .i_spi_rst (i_spi_rst),
  .i_pins    (i_pins),
  .o_reg_wr  (o_reg_wr)
);

`default_nettype wire

/* tb/spi_reg_tb.sv */
// Testbench for the SPI register-access subsystem
//   Clock, reset and a mode 3 SPI master task
//   Shadow register model with reference read function
//   Check queue with a comparing process, tests, timeout and summary
`timescale 1ns/1ns
`default_nettype none

module spi_reg_tb;
  import spi_reg_pkg::*;

  localparam logic [7:0] ADR_BASE = 8'h10;
  localparam logic [7:0] ADR_SIZE = 8'h0F;
  localparam logic [7:0] ADR_RESP = 8'h1F;
  localparam int         HALF     = 5;     // reg_clk cycles per SCK half-period
  localparam int         MAX_CYC  = 40000; // 73 frames of about 345 cycles, plus margin

  typedef struct packed {
    logic [31:0] exp;
    logic [31:0] act;
  } chk_t;

  logic       reg_clk    = 1'b0;
  logic       i_spi_rst  = 1'b1;
  logic       i_spi_cs   = 1'b1;           // Idle high
  logic       i_spi_ck   = 1'b1;           // Mode 3 idle level
  logic       i_spi_mosi = 1'b0;
  logic       o_spi_miso;
  reg_wr_t    o_reg_wr;

  logic [7:0] shadow [8];                  // Expected bank contents
  chk_t       chk_q [$];
  string      lbl_q [$];
  reg_wr_t    last_stb;
  int         n_stb    = 0;
  int         n_chk    = 0;
  int         n_err    = 0;
  int         n_tests  = 0;
  int         err_mark = 0;
  int         cyc      = 0;
  int         seed     = 23;

  spi_reg_top #(
    .G_ADR_BASE       (ADR_BASE),
    .G_ADR_SPACE_SIZE (ADR_SIZE),
    .G_ADR_RESPONDER  (ADR_RESP),
    .G_REG_NUM        (8)
  ) u_spi_reg_top (
    .reg_clk    (reg_clk),
    .i_spi_rst  (i_spi_rst),
    .i_spi_cs   (i_spi_cs),
    .i_spi_ck   (i_spi_ck),
    .i_spi_mosi (i_spi_mosi),
    .o_spi_miso (o_spi_miso),
    .o_reg_wr   (o_reg_wr)
  );

  always #10 reg_clk = ~reg_clk;           // 20 ns period

  // ------------------------------------------------------------
  // Timeout, strobe monitor and comparing process
  // ------------------------------------------------------------
  always @(posedge reg_clk) begin
    cyc <= cyc + 1;
    if (cyc == MAX_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYC);
      $display("TB FAILED");
      $finish;
    end
  end

  always @(posedge reg_clk) begin
    if (o_reg_wr.en) begin
      n_stb    <= n_stb + 1;
      last_stb <= o_reg_wr;                // Addr and data valid with en
    end
  end

  always @(posedge reg_clk) begin : compare
    chk_t  c;
    string lbl;
    while (chk_q.size() != 0) begin
      c   = chk_q.pop_front();
      lbl = lbl_q.pop_front();
      n_chk++;
      assert (c.exp == c.act)
        else begin
          n_err++;
          $display("Error at %0t ns: %s, expected %h, got %h", $time, lbl, c.exp, c.act);
        end
    end
  end

  task automatic push_check(input string lbl, input logic [31:0] exp, input logic [31:0] act);
    chk_t c;
    c.exp = exp;
    c.act = act;
    lbl_q.push_back(lbl);
    chk_q.push_back(c);
  endtask

  // Reference read, upper byte sel+1, lower byte sel, zero past register 7
  function automatic logic [15:0] exp_pair(input logic [7:0] sel);
    int         s;
    logic [7:0] hi;
    logic [7:0] lo;
    s  = sel;
    hi = (s + 1 < 8) ? shadow[s+1] : 8'h00;
    lo = (s < 8) ? shadow[s] : 8'h00;
    return {hi, lo};
  endfunction

  // ------------------------------------------------------------
  // SPI master, mode 3, MSB first
  // ------------------------------------------------------------
  task automatic spi_xfer(input logic [31:0] tx, input int nbits, output logic [15:0] rx);
    rx = '0;
    @(posedge reg_clk);
    i_spi_cs <= 1'b0;
    for (int i = 0; i < nbits; i++) begin
      repeat (HALF) @(posedge reg_clk);
      i_spi_ck   <= 1'b0;                  // Data changes on the falling edge
      i_spi_mosi <= tx[31-i];
      repeat (HALF) @(posedge reg_clk);
      i_spi_ck <= 1'b1;
      if (i >= 16) begin
        rx = {rx[14:0], o_spi_miso};       // Read half, rising edges 17..32
      end
    end
    repeat (2 * HALF) @(posedge reg_clk);  // cs hold after last rise
    i_spi_cs <= 1'b1;
    repeat (2 * HALF) @(posedge reg_clk);
  endtask

  task automatic write_reg(input logic [7:0] adr, input logic [23:0] data);
    int          a;
    int          n0;
    bit          exp_stb;
    logic [15:0] rx;
    a       = adr;
    n0      = n_stb;
    exp_stb = (a >= ADR_BASE) && (a <= ADR_BASE + ADR_SIZE) && (adr != ADR_RESP);
    spi_xfer({adr, data}, 32, rx);
    push_check($sformatf("strobe count adr %h", adr), {31'd0, exp_stb}, n_stb - n0);
    if (exp_stb) begin
      push_check("strobe word", {adr, data}, {last_stb.addr, last_stb.data});
      if (a - ADR_BASE < 8) begin
        shadow[a - ADR_BASE] = data[7:0];  // Only the low byte is stored
      end
    end
  endtask

  task automatic read_reg(input logic [7:0] sel);
    logic [15:0] rx;
    spi_xfer({ADR_RESP, sel, 16'h0000}, 32, rx);
    push_check($sformatf("read sel %0d", sel), {16'h0, exp_pair(sel)}, {16'h0, rx});
  endtask

  task automatic check_all();
    for (int s = 0; s < 8; s++) begin
      read_reg(8'(s));
    end
  endtask

  task automatic finish_test(input string name);
    while (chk_q.size() != 0) begin
      @(posedge reg_clk);
    end
    n_tests++;
    $display("Test %0d, %s: %0d errors", n_tests, name, n_err - err_mark);
    err_mark = n_err;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    logic [15:0] rx;
    logic [31:0] r;
    int          n0;
    for (int i = 0; i < 8; i++) begin
      shadow[i] = 8'h00;
    end
    repeat (10) @(posedge reg_clk);
    i_spi_rst <= 1'b0;
    repeat (2) @(posedge reg_clk);

    push_check("strobe after reset", 32'd0, {31'd0, o_reg_wr.en});
    push_check("miso after reset", 32'd0, {31'd0, o_spi_miso});
    check_all();
    finish_test("reset state");

    for (int i = 0; i < 8; i++) begin      // Distinct low bytes
      write_reg(ADR_BASE + 8'(i), {16'hC0DE ^ 16'(i), 8'h3C + 8'(i * 37)});
    end
    check_all();
    finish_test("write and read back");

    write_reg(8'h05, 24'hBAD005);
    write_reg(8'h30, 24'hBAD030);
    check_all();
    finish_test("out-of-space frames");

    write_reg(8'h1A, 24'h00001A);          // In space, no register behind it
    check_all();
    finish_test("unmapped address");

    n0 = n_stb;
    spi_xfer({8'h13, 24'h0000EE}, 12, rx); // cs rises after 12 bits
    push_check("strobe count aborted", 32'd0, n_stb - n0);
    write_reg(8'h13, 24'h00A55A);
    check_all();
    finish_test("aborted frame");

    for (int i = 0; i < 20; i++) begin
      r = $random(seed);
      if (r[0]) begin
        write_reg(ADR_BASE + 8'(r[31:8] % 15), 24'($random(seed)));
      end else begin
        read_reg(8'(r[31:8] % 8));
      end
    end
    finish_test("random traffic");

    repeat (4) @(posedge reg_clk);
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             n_tests, n_chk, n_err, u_spi_reg_top.u_slave.u_slave_assert.n_fail);
    if (n_err == 0 && u_spi_reg_top.u_slave.u_slave_assert.n_fail == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
